//--- mldsa_params_pkg.sv
// ML-DSA parameter package.
// Holds the arithmetic constants of the secret-key packer, the width of one
// packed code and the buffer type that the packer fills by group slots and
// drains by key words.

package mldsa_params_pkg;

    // ============================================================
    // Arithmetic constants
    // ============================================================

    // The ML-DSA modulus, 2^23 - 2^13 + 1.
    localparam logic [22:0] mldsa_q = 23'd8380417;

    // Width of one coefficient as it is stored in the coefficient memory.
    localparam int coeff_w = 24;

    // ============================================================
    // Packing geometry
    // ============================================================

    // One code per coefficient, holding eta minus the value (eta = 2).
    localparam int code_w = 3;

    // Coefficients per memory word, which is also the lane width.
    localparam int lane_coeffs = 4;

    // Two lanes of codes make one group per cycle.
    localparam int group_w = 2 * lane_coeffs * code_w;

    // Width of one word written to the key memory.
    localparam int key_word_w = 32;

    // Four groups of 24 bits line up exactly with three key words of 32 bits.
    // The packer writes the slot view and reads the word view.
    typedef union packed {
        logic [3:0][group_w-1:0]    slot;
        logic [2:0][key_word_w-1:0] word;
    } pack_buf_u;

endpackage

//--- skenc_mem_pkg.sv
// Memory request package.
// Defines the operation code and the request word used on the coefficient
// read ports and on the key memory write port.

package skenc_mem_pkg;

    // ============================================================
    // Request encoding
    // ============================================================

    // Default address width of every memory port.
    localparam int MEM_ADDR_WIDTH = 15;

    // Operation carried by a request.
    // An idle request must always come with a zero address.
    typedef enum logic [1:0] {
        rw_idle  = 2'd0,
        rw_read  = 2'd1,
        rw_write = 2'd2
    } rw_op_e;

    // One request per cycle and per port, with no handshake.
    typedef struct packed {
        rw_op_e                    op;
        logic [MEM_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    // Value driven on a port that has nothing to do.
    localparam mem_req_t mem_req_idle = '{op: rw_idle, addr: '0};

endpackage

//--- coeff_lane_if.sv
// Coefficient lane interface.
// Carries one lane's group of four encoded coefficients from an encoder to
// the packer, together with its valid and error flags.

`timescale 1ns/1ps

interface coeff_lane_if;
    import mldsa_params_pkg::*;

    // High for one cycle per encoded memory word.
    logic valid;

    // Code for coefficient i sits in bits 3i+2..3i.
    logic [lane_coeffs-1:0][code_w-1:0] codes;

    // Set when any coefficient of the word was outside -2..2 mod Q.
    logic error;

    modport enc (
        output valid,
        output codes,
        output error
    );

    modport pack (
        input valid,
        input codes,
        input error
    );

endinterface

//--- skenc_read_ctrl.sv
// Secret-key encoder read controller.
// Starts a run on an enable pulse, then issues one paired read per cycle
// (port A at src+2g, port B at src+2g+1) until every group of s1 and s2 has
// been requested. An abort from the packer or zeroize ends the run at once.

`timescale 1ns/1ps

module skenc_read_ctrl #(
    parameter int MLDSA_L        = 7,
    parameter int MLDSA_K        = 8,
    parameter int MLDSA_N        = 256,
    parameter int MEM_ADDR_WIDTH = 15
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    skencode_enable,
    input  logic [MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic                    abort,
    output skenc_mem_pkg::mem_req_t mem_a_rd_req,
    output skenc_mem_pkg::mem_req_t mem_b_rd_req,
    output logic                    busy
);
    import skenc_mem_pkg::*;

    // Each group is eight coefficients, two memory words of four.
    localparam int total_groups = (MLDSA_K + MLDSA_L) * MLDSA_N / 8;
    localparam int grp_w        = $clog2(total_groups + 1);

    localparam logic st_idle = 1'b0;
    localparam logic st_read = 1'b1;

    logic                      state;
    logic [grp_w-1:0]          grp_cnt;
    logic [MEM_ADDR_WIDTH-1:0] src_lock;
    logic [MEM_ADDR_WIDTH-1:0] base_sel;
    logic [MEM_ADDR_WIDTH-1:0] addr_a;
    logic [MEM_ADDR_WIDTH-1:0] addr_b;

    // The first pair goes out straight from the enable cycle, before the
    // base address has been latched.
    assign base_sel = (state == st_idle) ? src_base_addr : src_lock;
    assign addr_a   = base_sel + MEM_ADDR_WIDTH'({grp_cnt, 1'b0});
    assign addr_b   = addr_a + MEM_ADDR_WIDTH'(1);

    // Busy is high exactly while read pairs are on the ports.
    assign busy = (state == st_read);

    // ============================================================
    // Run FSM and request registers
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= st_idle;
            grp_cnt      <= '0;
            src_lock     <= '0;
            mem_a_rd_req <= mem_req_idle;
            mem_b_rd_req <= mem_req_idle;
        end else if (zeroize) begin
            state        <= st_idle;
            grp_cnt      <= '0;
            src_lock     <= '0;
            mem_a_rd_req <= mem_req_idle;
            mem_b_rd_req <= mem_req_idle;
        end else if (abort) begin
            // Reads in flight are dropped by the packer.
            state        <= st_idle;
            grp_cnt      <= '0;
            mem_a_rd_req <= mem_req_idle;
            mem_b_rd_req <= mem_req_idle;
        end else begin
            case (state)
                st_idle: begin
                    mem_a_rd_req <= mem_req_idle;
                    mem_b_rd_req <= mem_req_idle;
                    if (skencode_enable) begin
                        state        <= st_read;
                        src_lock     <= src_base_addr;
                        grp_cnt      <= grp_w'(1);
                        mem_a_rd_req <= '{op: rw_read, addr: addr_a};
                        mem_b_rd_req <= '{op: rw_read, addr: addr_b};
                    end
                end
                default: begin
                    if (grp_cnt == grp_w'(total_groups)) begin
                        // The last pair was on the ports this cycle.
                        state        <= st_idle;
                        grp_cnt      <= '0;
                        mem_a_rd_req <= mem_req_idle;
                        mem_b_rd_req <= mem_req_idle;
                    end else begin
                        grp_cnt      <= grp_cnt + grp_w'(1);
                        mem_a_rd_req <= '{op: rw_read, addr: addr_a};
                        mem_b_rd_req <= '{op: rw_read, addr: addr_b};
                    end
                end
            endcase
        end
    end

endmodule

//--- coeff_lane_encoder.sv
// Coefficient lane encoder.
// Maps four coefficients of one memory word to 3-bit codes (2 minus the
// value, for values -2..2 mod Q) and flags any other value. The codes, the
// combined error and the valid flag are registered onto the lane.

`timescale 1ns/1ps

module coeff_lane_encoder (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic [mldsa_params_pkg::lane_coeffs-1:0][mldsa_params_pkg::coeff_w-1:0] rd_data,
    input  logic rd_valid,
    coeff_lane_if.enc lane
);
    import mldsa_params_pkg::*;

    // Negative values as they appear in memory.
    localparam logic [coeff_w-1:0] q_minus_1 = coeff_w'(mldsa_q) - coeff_w'(1);
    localparam logic [coeff_w-1:0] q_minus_2 = coeff_w'(mldsa_q) - coeff_w'(2);

    logic [lane_coeffs-1:0][code_w-1:0] codes_d;
    logic [lane_coeffs-1:0]             bad;

    // ============================================================
    // Decode
    // ============================================================

    always_comb begin
        for (int i = 0; i < lane_coeffs; i++) begin
            bad[i] = 1'b0;
            case (rd_data[i])
                coeff_w'(0): codes_d[i] = code_w'(2);
                coeff_w'(1): codes_d[i] = code_w'(1);
                coeff_w'(2): codes_d[i] = code_w'(0);
                q_minus_1:   codes_d[i] = code_w'(3);
                q_minus_2:   codes_d[i] = code_w'(4);
                default: begin
                    codes_d[i] = '0;
                    bad[i]     = 1'b1;
                end
            endcase
        end
    end

    // ============================================================
    // Output register
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane.valid <= 1'b0;
            lane.error <= 1'b0;
            lane.codes <= '0;
        end else if (zeroize) begin
            lane.valid <= 1'b0;
            lane.error <= 1'b0;
            lane.codes <= '0;
        end else begin
            lane.valid <= rd_valid;
            lane.error <= rd_valid & (|bad);
            if (rd_valid) begin
                lane.codes <= codes_d;
            end
        end
    end

endmodule

//--- skenc_packer.sv
// Secret-key packer.
// Joins the codes of both lanes into one 24-bit group per cycle, collects
// four groups in a fill buffer and hands each full buffer to a drain buffer
// that goes out as three 32-bit writes to the key memory. Ends a run with a
// done pulse, or with a one-cycle abort when a lane reports a bad value.

`timescale 1ns/1ps

module skenc_packer #(
    parameter int MEM_ADDR_WIDTH = 15
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic [MEM_ADDR_WIDTH-1:0] dest_base_addr,
    input  logic                    busy,
    coeff_lane_if.pack              lane_a,
    coeff_lane_if.pack              lane_b,
    output skenc_mem_pkg::mem_req_t keymem_wr_req,
    output logic [mldsa_params_pkg::key_word_w-1:0] keymem_wr_data,
    output logic                    skencode_done,
    output logic                    abort
);
    import mldsa_params_pkg::*;
    import skenc_mem_pkg::*;

    logic                      busy_q;
    logic                      run_active;
    logic [MEM_ADDR_WIDTH-1:0] dest_lock;
    logic [MEM_ADDR_WIDTH-1:0] wr_cnt;
    logic [1:0]                slot_cnt;
    logic [1:0]                word_sel;
    logic                      draining;
    pack_buf_u                 fill_buf;
    pack_buf_u                 fill_next;
    pack_buf_u                 drain_buf;
    logic [group_w-1:0]        group;
    logic                      grp_valid;
    logic                      grp_error;
    logic                      last_word;
    logic                      run_end;

    // Lane A holds the lower four codes of the group.
    assign group     = {lane_b.codes, lane_a.codes};
    assign grp_valid = run_active & lane_a.valid & lane_b.valid;
    assign grp_error = grp_valid & (lane_a.error | lane_b.error);
    assign last_word = draining & (word_sel == 2'd2);

    // After busy falls only two groups are still in flight, and the last
    // one always completes a buffer, so an empty fill buffer at the final
    // drain word means the stream is finished.
    assign run_end = run_active & last_word & ~busy & (slot_cnt == 2'd0) & ~grp_valid;

    always_comb begin
        fill_next                = fill_buf;
        fill_next.slot[slot_cnt] = group;
    end

    // ============================================================
    // Fill, drain and run control
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q        <= 1'b0;
            run_active    <= 1'b0;
            dest_lock     <= '0;
            wr_cnt        <= '0;
            slot_cnt      <= '0;
            word_sel      <= '0;
            draining      <= 1'b0;
            fill_buf      <= '0;
            drain_buf     <= '0;
            skencode_done <= 1'b0;
            abort         <= 1'b0;
        end else if (zeroize) begin
            busy_q        <= 1'b0;
            run_active    <= 1'b0;
            dest_lock     <= '0;
            wr_cnt        <= '0;
            slot_cnt      <= '0;
            word_sel      <= '0;
            draining      <= 1'b0;
            fill_buf      <= '0;
            drain_buf     <= '0;
            skencode_done <= 1'b0;
            abort         <= 1'b0;
        end else begin
            busy_q        <= busy;
            abort         <= grp_error;
            skencode_done <= run_end;

            if (grp_error) begin
                // Stop at once, pending words of the run are dropped.
                run_active <= 1'b0;
                wr_cnt     <= '0;
                slot_cnt   <= '0;
                word_sel   <= '0;
                draining   <= 1'b0;
            end else begin
                if (busy && !busy_q) begin
                    run_active <= 1'b1;
                    dest_lock  <= dest_base_addr;
                    wr_cnt     <= '0;
                end else if (run_end) begin
                    run_active <= 1'b0;
                end

                if (grp_valid) begin
                    fill_buf <= fill_next;
                    slot_cnt <= slot_cnt + 2'd1;
                end

                if (draining) begin
                    wr_cnt   <= wr_cnt + MEM_ADDR_WIDTH'(1);
                    word_sel <= word_sel + 2'd1;
                end

                // A full buffer is handed over while the previous one has
                // already left, four fill cycles cover three drain cycles.
                if (grp_valid && slot_cnt == 2'd3) begin
                    drain_buf <= fill_next;
                    draining  <= 1'b1;
                    word_sel  <= '0;
                end else if (last_word) begin
                    draining  <= 1'b0;
                    word_sel  <= '0;
                end
            end
        end
    end

    // ============================================================
    // Key memory write port
    // ============================================================

    always_comb begin
        keymem_wr_req  = mem_req_idle;
        keymem_wr_data = '0;
        if (draining) begin
            keymem_wr_req  = '{op: rw_write, addr: dest_lock + wr_cnt};
            keymem_wr_data = drain_buf.word[word_sel];
        end
    end

endmodule

//--- skencode_top.sv
// Secret-key encoder top level.
// Packs the s1 and s2 polynomials of an ML-DSA key into a stream of 32-bit
// key words. The read controller fetches two coefficient words per cycle,
// one encoder per read port turns them into codes, and the packer merges
// both lanes and writes the key memory.

`timescale 1ns/1ps

module skencode_top #(
    parameter int MLDSA_L        = 7,
    parameter int MLDSA_K        = 8,
    parameter int MLDSA_N        = 256,
    parameter int MEM_ADDR_WIDTH = 15
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic skencode_enable,
    input  logic [MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic [MEM_ADDR_WIDTH-1:0] dest_base_addr,
    input  logic [mldsa_params_pkg::lane_coeffs-1:0][mldsa_params_pkg::coeff_w-1:0] mem_a_rd_data,
    input  logic [mldsa_params_pkg::lane_coeffs-1:0][mldsa_params_pkg::coeff_w-1:0] mem_b_rd_data,
    input  logic mem_rd_data_valid,
    output skenc_mem_pkg::mem_req_t mem_a_rd_req,
    output skenc_mem_pkg::mem_req_t mem_b_rd_req,
    output skenc_mem_pkg::mem_req_t keymem_wr_req,
    output logic [mldsa_params_pkg::key_word_w-1:0] keymem_wr_data,
    output logic skencode_done,
    output logic skencode_error
);

    logic busy;

    coeff_lane_if lane_a_if ();
    coeff_lane_if lane_b_if ();

    // The packer's abort is the error pulse and also stops the reads.
    skenc_read_ctrl #(
        .MLDSA_L        (MLDSA_L),
        .MLDSA_K        (MLDSA_K),
        .MLDSA_N        (MLDSA_N),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) read_ctrl0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .skencode_enable (skencode_enable),
        .src_base_addr   (src_base_addr),
        .abort           (skencode_error),
        .mem_a_rd_req    (mem_a_rd_req),
        .mem_b_rd_req    (mem_b_rd_req),
        .busy            (busy)
    );

    coeff_lane_encoder enc_a (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .rd_data  (mem_a_rd_data),
        .rd_valid (mem_rd_data_valid),
        .lane     (lane_a_if.enc)
    );

    coeff_lane_encoder enc_b (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .rd_data  (mem_b_rd_data),
        .rd_valid (mem_rd_data_valid),
        .lane     (lane_b_if.enc)
    );

    skenc_packer #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) packer0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .dest_base_addr (dest_base_addr),
        .busy           (busy),
        .lane_a         (lane_a_if.pack),
        .lane_b         (lane_b_if.pack),
        .keymem_wr_req  (keymem_wr_req),
        .keymem_wr_data (keymem_wr_data),
        .skencode_done  (skencode_done),
        .abort          (skencode_error)
    );

endmodule

//--- skencode_mem_model.sv
// Coefficient memory model for the testbench.
// Dual-port memory of four 24-bit coefficients per word. Both ports return
// their read data one cycle after the request, with one shared valid flag.

`timescale 1ns/1ps

module skencode_mem_model (
    input  logic clk,
    input  logic reset_n,
    input  skenc_mem_pkg::mem_req_t a_req,
    input  skenc_mem_pkg::mem_req_t b_req,
    output logic [mldsa_params_pkg::lane_coeffs-1:0][mldsa_params_pkg::coeff_w-1:0] a_data,
    output logic [mldsa_params_pkg::lane_coeffs-1:0][mldsa_params_pkg::coeff_w-1:0] b_data,
    output logic rd_valid
);
    import mldsa_params_pkg::*;
    import skenc_mem_pkg::*;

    // The testbench loads the image directly into this array.
    logic [lane_coeffs-1:0][coeff_w-1:0] mem [0:(1 << MEM_ADDR_WIDTH)-1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_data   <= '0;
            b_data   <= '0;
            rd_valid <= 1'b0;
        end else begin
            // Both ports are always requested together.
            rd_valid <= (a_req.op == rw_read);
            if (a_req.op == rw_read) begin
                a_data <= mem[a_req.addr];
            end
            if (b_req.op == rw_read) begin
                b_data <= mem[b_req.addr];
            end
        end
    end

endmodule

//--- tb_skencode.sv
// Testbench for the secret-key encoder.
// Loads coefficient images into the memory model, runs the encoder and
// checks every key memory write against a reference packer built from the
// packing rule. Covers full runs, the code map, bad values and zeroize.

`timescale 1ns/1ps

module tb_skencode;
    import mldsa_params_pkg::*;
    import skenc_mem_pkg::*;

    localparam int l_cnt         = 7;
    localparam int k_cnt         = 8;
    localparam int n_cnt         = 256;
    localparam int coeff_words   = (k_cnt + l_cnt) * n_cnt / 4;
    localparam int groups        = coeff_words / 2;
    localparam int words_per_run = (k_cnt + l_cnt) * n_cnt * 3 / 32;
    localparam int q             = int'(mldsa_q);

    logic clk;
    logic reset_n;
    logic zeroize;
    logic skencode_enable;
    logic [MEM_ADDR_WIDTH-1:0] src_base_addr;
    logic [MEM_ADDR_WIDTH-1:0] dest_base_addr;
    logic [lane_coeffs-1:0][coeff_w-1:0] mem_a_rd_data;
    logic [lane_coeffs-1:0][coeff_w-1:0] mem_b_rd_data;
    logic mem_rd_data_valid;
    mem_req_t mem_a_rd_req;
    mem_req_t mem_b_rd_req;
    mem_req_t keymem_wr_req;
    logic [31:0] keymem_wr_data;
    logic skencode_done;
    logic skencode_error;

    integer seed;
    int errors;
    int tests_run;
    int tests_failed;
    logic [MEM_ADDR_WIDTH-1:0] exp_src;
    logic [MEM_ADDR_WIDTH-1:0] exp_dest;
    int wr_count;
    int done_count;
    int err_count;
    int wr_after_err;
    logic [31:0] exp_word;
    logic [31:0] first_word;

    skencode_top #(
        .MLDSA_L        (l_cnt),
        .MLDSA_K        (k_cnt),
        .MLDSA_N        (n_cnt),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) dut0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .skencode_enable   (skencode_enable),
        .src_base_addr     (src_base_addr),
        .dest_base_addr    (dest_base_addr),
        .mem_a_rd_data     (mem_a_rd_data),
        .mem_b_rd_data     (mem_b_rd_data),
        .mem_rd_data_valid (mem_rd_data_valid),
        .mem_a_rd_req      (mem_a_rd_req),
        .mem_b_rd_req      (mem_b_rd_req),
        .keymem_wr_req     (keymem_wr_req),
        .keymem_wr_data    (keymem_wr_data),
        .skencode_done     (skencode_done),
        .skencode_error    (skencode_error)
    );

    skencode_mem_model mem0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .a_req    (mem_a_rd_req),
        .b_req    (mem_b_rd_req),
        .a_data   (mem_a_rd_data),
        .b_data   (mem_b_rd_data),
        .rd_valid (mem_rd_data_valid)
    );

    always #20 clk = ~clk;

    // ============================================================
    // Reference model
    // ============================================================

    // A coefficient stands for a signed value in -2..2, the code is 2 minus it.
    function automatic logic [2:0] ref_code(input logic [23:0] c);
        int v;
        if (int'(c) > q / 2) begin
            v = int'(c) - q;
        end else begin
            v = int'(c);
        end
        return 3'(2 - v);
    endfunction

    function automatic logic [23:0] legal_value(input int idx);
        case (idx % 5)
            0:       return 24'd0;
            1:       return 24'd1;
            2:       return 24'd2;
            3:       return 24'(q - 1);
            default: return 24'(q - 2);
        endcase
    endfunction

    // The key stream is every code in read order, three bits each, LSB first.
    function automatic logic [31:0] pack_expected(input logic [14:0] src, input int j);
        logic [31:0] w;
        logic [2:0]  code;
        int          p;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            p    = (32 * j + b) / 3;
            code = ref_code(mem0.mem[15'(int'(src) + p / 4)][2'(p % 4)]);
            w[5'(b)] = code[2'((32 * j + b) % 3)];
        end
        return w;
    endfunction

    // ============================================================
    // Write checker
    // ============================================================

    always @(posedge clk) begin
        if (keymem_wr_req.op == rw_write) begin
            exp_word = pack_expected(exp_src, wr_count);
            assert (keymem_wr_req.addr == 15'(int'(exp_dest) + wr_count)) else begin
                $display("mismatch keymem_wr_req.addr: got %h expected %h",
                         keymem_wr_req.addr, 15'(int'(exp_dest) + wr_count));
                errors++;
            end
            assert (keymem_wr_data == exp_word) else begin
                $display("mismatch keymem_wr_data: got %h expected %h (word %0d)",
                         keymem_wr_data, exp_word, wr_count);
                errors++;
            end
            if (wr_count == 0) begin
                first_word = keymem_wr_data;
            end
            if (err_count > 0) begin
                wr_after_err++;
            end
            wr_count++;
        end
        if (skencode_done) begin
            done_count++;
        end
        if (skencode_error) begin
            err_count++;
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    task automatic fill_random(input logic [14:0] src);
        for (int w = 0; w < coeff_words; w++) begin
            for (int i = 0; i < 4; i++) begin
                mem0.mem[15'(int'(src) + w)][2'(i)] =
                    legal_value(int'($random(seed) & 32'h7fff_ffff));
            end
        end
    endtask

    task automatic start_run(input logic [14:0] src, input logic [14:0] dest);
        exp_src         = src;
        exp_dest        = dest;
        wr_count        = 0;
        done_count      = 0;
        err_count       = 0;
        wr_after_err    = 0;
        src_base_addr   = src;
        dest_base_addr  = dest;
        skencode_enable = 1'b1;
        @(negedge clk);
        skencode_enable = 1'b0;
    endtask

    task automatic wait_done();
        int t;
        for (t = 0; t < 3000 && !skencode_done; t++) begin
            @(negedge clk);
        end
        if (!skencode_done) begin
            $display("timeout: no done pulse within 3000 cycles");
            errors++;
        end
    endtask

    task automatic check_full_run();
        wait_done();
        repeat (4) @(negedge clk);
        assert (wr_count == words_per_run) else begin
            $display("mismatch write count: got %h expected %h", wr_count, words_per_run);
            errors++;
        end
        assert (done_count == 1 && err_count == 0) else begin
            $display("run ended with %0d done pulses and %0d error pulses",
                     done_count, err_count);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - err_before);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        int e0;
        int g;
        int t;
        seed            = 32'hb023_b33c;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        clk             = 1'b0;
        reset_n         = 1'b0;
        zeroize         = 1'b0;
        skencode_enable = 1'b0;
        src_base_addr   = '0;
        dest_base_addr  = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // Full run on random legal coefficients.
        e0 = errors;
        fill_random(15'h0000);
        start_run(15'h0000, 15'h0100);
        check_full_run();
        report_test("full random run", e0);

        // Image that cycles through 0, 1, 2, Q-1, Q-2.
        e0 = errors;
        for (int w = 0; w < coeff_words; w++) begin
            for (int i = 0; i < 4; i++) begin
                mem0.mem[15'(4096 + w)][2'(i)] = legal_value(4 * w + i);
            end
        end
        start_run(15'h1000, 15'h0200);
        check_full_run();
        // Codes 2,1,0,3,4,2,1,0,3,4 and the low two bits of 2.
        assert (first_word == 32'ha305_460a) else begin
            $display("mismatch keymem_wr_data: got %h expected %h", first_word,
                     32'ha305_460a);
            errors++;
        end
        report_test("legal value codes", e0);

        // One bad coefficient at a random group.
        e0 = errors;
        fill_random(15'h3000);
        g = int'($random(seed) & 32'h7fff_ffff) % groups;
        mem0.mem[15'(12288 + 2 * g + 1)][2'd2] = 24'h00_0007;
        start_run(15'h3000, 15'h0300);
        for (t = 0; t < 3000 && !skencode_error; t++) begin
            @(negedge clk);
        end
        if (!skencode_error) begin
            $display("timeout: no error pulse for bad value in group %0d", g);
            errors++;
        end
        for (t = 0; t < 10 && !(mem_a_rd_req.op == rw_idle && mem_b_rd_req.op == rw_idle);
             t++) begin
            @(negedge clk);
        end
        if (!(mem_a_rd_req.op == rw_idle && mem_b_rd_req.op == rw_idle)) begin
            $display("read requests did not return to idle after the error");
            errors++;
        end
        repeat (40) @(negedge clk);
        assert (done_count == 0 && err_count == 1 && wr_after_err <= 3) else begin
            $display("after error: %0d done pulses, %0d error pulses, %0d late writes",
                     done_count, err_count, wr_after_err);
            errors++;
        end
        report_test("bad coefficient", e0);

        // Zeroize in the middle of a run, then a clean run.
        e0 = errors;
        start_run(15'h0000, 15'h0400);
        for (t = 0; t < 3000 && wr_count < 100; t++) begin
            @(negedge clk);
        end
        if (wr_count < 100) begin
            $display("timeout: run stalled before 100 writes");
            errors++;
        end
        zeroize = 1'b1;
        repeat (3) @(negedge clk);
        assert (mem_a_rd_req == mem_req_idle && mem_b_rd_req == mem_req_idle) else begin
            $display("mismatch mem_a_rd_req/mem_b_rd_req: got %h %h expected %h",
                     mem_a_rd_req, mem_b_rd_req, mem_req_idle);
            errors++;
        end
        assert (keymem_wr_req == mem_req_idle && !skencode_done && !skencode_error) else begin
            $display("mismatch keymem_wr_req: got %h expected %h (done %h, error %h)",
                     keymem_wr_req, mem_req_idle, skencode_done, skencode_error);
            errors++;
        end
        zeroize = 1'b0;
        @(negedge clk);
        start_run(15'h0000, 15'h0400);
        check_full_run();
        report_test("zeroize mid-run", e0);

        // Two runs back to back with their own bases.
        e0 = errors;
        fill_random(15'h5000);
        fill_random(15'h6000);
        start_run(15'h5000, 15'h0500);
        check_full_run();
        start_run(15'h6000, 15'h0900);
        check_full_run();
        report_test("back-to-back runs", e0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- skencode_top.f
mldsa_params_pkg.sv
skenc_mem_pkg.sv
coeff_lane_if.sv
skenc_read_ctrl.sv
coeff_lane_encoder.sv
skenc_packer.sv
skencode_top.sv
skencode_mem_model.sv
tb_skencode.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_skencode -f skencode_top.f -o tb_skencode
	./obj_dir/tb_skencode | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
